/* build.f */
mult_pkg.sv
int_mac.sv
short_mult.sv
mulh_ctrl.sv
subword_dot.sv
nn_mult.sv
nn_mult_checker.sv
tb_nn_mult.sv

/* tb_nn_mult.sv */
// Subword MAC testbench
`timescale 1ns/1ps

module tb_nn_mult import mult_pkg::*; ();

  localparam logic [31:0] LCG_SEED    = 32'h2c9b_1394;
  // 9 opcodes times 6 corner sets, plus two back-pressure runs
  localparam int          N_DIRECTED  = 56;
  localparam int          N_RANDOM    = 600;
  localparam int          TIMEOUT_CYC = (N_DIRECTED + N_RANDOM) * 8 + 100;
  localparam int          CLK_PERIOD  = 40;

  logic              clk;
  logic              rst_n;
  logic              enable;
  mult_req_t         req;
  logic              ex_ready;
  logic [DATA_W-1:0] result;
  logic              multicycle;
  logic              ready;
  logic [DATA_W-1:0] result_q;
  logic [31:0]       lcg_state;
  int                cycles;
  int                checks;
  int                value_errs;
  int                timing_errs;

  nn_mult u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable),
    .req_i        (req),
    .ex_ready_i   (ex_ready),
    .result_o     (result),
    .multicycle_o (multicycle),
    .ready_o      (ready)
  );

  nn_mult_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (enable),
    .req_i         (req),
    .ex_ready_i    (ex_ready),
    .result_i      (result),
    .multicycle_i  (multicycle),
    .ready_i       (ready),
    .checks_o      (checks),
    .value_errs_o  (value_errs),
    .timing_errs_o (timing_errs)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Partial sum of the last high-word step, fed back as op_c
  always @(posedge clk) begin
    result_q <= result;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles before all tests were issued", cycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  // Zero, all ones, most negative
  function automatic logic [DATA_W-1:0] corner(input int k);
    case (k % 3)
      0:       return '0;
      1:       return '1;
      default: return 32'h8000_0000;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[31:30] != 2'b00) begin
      return next_rand();
    end
    return corner(r[7:0]);
  endfunction

  function automatic logic [1:0] legal_signed(input int k);
    case (k % 3)
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  function automatic mult_op_e op_by_index(input int k);
    case (k % 9)
      0:       return MUL_MAC32;
      1:       return MUL_MSU32;
      2:       return MUL_I;
      3:       return MUL_IR;
      4:       return MUL_H;
      5:       return MUL_DOT8;
      6:       return MUL_DOT4;
      7:       return MUL_DOT2;
      default: return MUL_DOT16;
    endcase
  endfunction

  task automatic run_high_word(input mult_req_t r, input int stall);
    req      = r;
    req.op_c = '0;
    enable   = 1'b1;
    @(posedge clk);
    @(negedge clk);
    while (multicycle) begin
      @(negedge clk);
      req.op_c = result_q;
    end
    // Back-pressure in FINISH
    if (stall > 0) begin
      ex_ready = 1'b0;
      repeat (stall) @(negedge clk);
      ex_ready = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic issue(input mult_req_t r, input logic en, input int stall);
    @(negedge clk);
    if (r.op == MUL_H) begin
      run_high_word(r, stall);
    end else begin
      req    = r;
      enable = en;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    mult_req_t   r;
    logic [31:0] rnd;
    logic [31:0] imm_r;
    lcg_state = LCG_SEED;
    rst_n     = 1'b0;
    enable    = 1'b0;
    ex_ready  = 1'b1;
    req       = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int k = 0; k < 9; k++) begin
      for (int j = 0; j < 6; j++) begin
        r               = '0;
        r.op            = op_by_index(k);
        r.op_a          = corner(j);
        r.op_b          = corner(j + 1);
        r.op_c          = corner(j + 2);
        r.imm           = j[0] ? 5'd31 : 5'd0;
        r.short_signed  = legal_signed(j);
        r.short_subword = j[1];
        r.dot_signed    = j[1:0];
        issue(r, 1'b1, 0);
      end
    end

    // Long stall, then a signed high-word op right behind it
    r              = '0;
    r.op           = MUL_H;
    r.op_a         = '1;
    r.op_b         = 32'hffff_0001;
    r.short_signed = 2'b00;
    issue(r, 1'b1, 3);
    r.op_a         = 32'h8000_0000;
    r.short_signed = 2'b11;
    issue(r, 1'b1, 0);

    for (int n = 0; n < N_RANDOM; n++) begin
      rnd             = next_rand();
      imm_r           = next_rand();
      r.op            = op_by_index(rnd[31:16]);
      r.short_signed  = legal_signed(rnd[15:8]);
      r.short_subword = rnd[7];
      r.dot_signed    = rnd[6:5];
      r.op_a          = pick_operand();
      r.op_b          = pick_operand();
      r.op_c          = pick_operand();
      if (imm_r[31:29] == 3'd0) begin
        r.imm = 5'd0;
      end else if (imm_r[31:29] == 3'd1) begin
        r.imm = 5'd31;
      end else begin
        r.imm = imm_r[4:0];
      end
      issue(r, rnd[2], rnd[4:3]);
    end

    @(negedge clk);
    @(negedge clk);
    $display("Checks %0d, result errors %0d, timing errors %0d",
             checks, value_errs, timing_errs);
    if (value_errs == 0 && timing_errs == 0 && checks > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* nn_mult_checker.sv */
// Subword MAC result checker
`timescale 1ns/1ps

module nn_mult_checker import mult_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_req_t         req_i,
  input  logic              ex_ready_i,
  input  logic [DATA_W-1:0] result_i,
  input  logic              multicycle_i,
  input  logic              ready_i,
  output int                checks_o,
  output int                value_errs_o,
  output int                timing_errs_o
);

  int checks      = 0;
  int value_errs  = 0;
  int timing_errs = 0;
  // 0 outside a high-word op, 1 to 3 in the steps, 4 in FINISH
  int step_cnt    = 0;

  assign checks_o      = checks;
  assign value_errs_o  = value_errs;
  assign timing_errs_o = timing_errs;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Bottom w bits of val, optionally sign-extended
  function automatic longint extend(input logic [DATA_W-1:0] val, input int w, input logic sgn);
    longint v;
    v = longint'(val) & ((longint'(1) << w) - 1);
    if (sgn && val[w-1]) begin
      v = v - (longint'(1) << w);
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] expected_result(input mult_req_t r);
    logic [DATA_W-1:0] half_a;
    logic [DATA_W-1:0] half_b;
    logic [DATA_W-1:0] low;
    longint            prod;
    longint            sum;
    int                lane_w;
    lane_w = 0;
    case (r.op)
      MUL_MAC32: return r.op_c + r.op_a * r.op_b;
      MUL_MSU32: return r.op_c - r.op_a * r.op_b;
      MUL_H: begin
        prod = extend(r.op_a, DATA_W, r.short_signed[0]) *
               extend(r.op_b, DATA_W, r.short_signed[1]);
        return prod[63:32];
      end
      MUL_I, MUL_IR: begin
        half_a = r.short_subword ? r.op_a >> HALF_W : r.op_a;
        half_b = r.short_subword ? r.op_b >> HALF_W : r.op_b;
        prod   = extend(half_a, HALF_W, r.short_signed[0]) *
                 extend(half_b, HALF_W, r.short_signed[1]);
        sum    = extend(r.op_c, DATA_W, 1'b1) + prod;
        // Rounding adds half of the weight dropped by the shift
        if (r.op == MUL_IR && r.imm != 0) begin
          sum = sum + (longint'(1) << (r.imm - 1));
        end
        low = sum[31:0];
        if (r.short_signed[0]) begin
          return $signed(low) >>> r.imm;
        end
        return low >> r.imm;
      end
      MUL_DOT8:  lane_w = 8;
      MUL_DOT4:  lane_w = 4;
      MUL_DOT2:  lane_w = 2;
      MUL_DOT16: lane_w = 16;
      default:   return '0;
    endcase
    sum = longint'(r.op_c);
    for (int i = 0; i < DATA_W / lane_w; i++) begin
      sum = sum + extend(r.op_a >> (i * lane_w), lane_w, r.dot_signed[1]) *
                  extend(r.op_b >> (i * lane_w), lane_w, r.dot_signed[0]);
    end
    return sum[31:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////

  task automatic timing_error(input string what);
    timing_errs++;
    $display("** Error at %0t: %s, ready_o %b multicycle_o %b",
             $time, what, ready_i, multicycle_i);
  endtask

  task automatic compare_result();
    logic [DATA_W-1:0] exp;
    exp = expected_result(req_i);
    checks++;
    if (result_i !== exp) begin
      value_errs++;
      $display("** Error at %0t: opcode %0h expected %08h, got %08h",
               $time, req_i.op, exp, result_i);
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      step_cnt = 0;
    end else if (step_cnt > 0 && step_cnt < 4) begin
      if (!multicycle_i || ready_i) begin
        timing_error($sformatf("high-word step %0d not busy", step_cnt));
      end
      step_cnt++;
    end else if (step_cnt == 4) begin
      // FINISH, checked again on every back-pressure cycle
      if (!ready_i || multicycle_i) begin
        timing_error("high-word result not ready");
      end else begin
        compare_result();
      end
      if (ex_ready_i) begin
        step_cnt = 0;
      end
    end else if (enable_i && req_i.op == MUL_H) begin
      if (ready_i || multicycle_i) begin
        timing_error("ready_o high in high-word accept cycle");
      end
      step_cnt = 1;
    end else begin
      if (!ready_i || multicycle_i) begin
        timing_error("single-cycle op not ready");
      end else begin
        compare_result();
      end
    end
  end

endmodule

/* nn_mult.sv */
// Subword multiply-accumulate unit
`timescale 1ns/1ps

module nn_mult import mult_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_req_t         req_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              multicycle_o,
  output logic              ready_o
);

  logic [DATA_W-1:0] int_result;
  logic [DATA_W-1:0] short_result;
  logic [DATA_W-1:0] dot8_result;
  logic [DATA_W-1:0] dot4_result;
  logic [DATA_W-1:0] dot2_result;
  logic [DATA_W-1:0] dot16_result;
  mulh_ctl_t         mulh_ctl;
  logic              mac_carry;

  ////////////////////////////////////////////////////////////
  // Datapaths
  ////////////////////////////////////////////////////////////

  int_mac u_int_mac (
    .req_i    (req_i),
    .result_o (int_result)
  );

  short_mult u_short_mult (
    .req_i       (req_i),
    .mulh_ctl_i  (mulh_ctl),
    .result_o    (short_result),
    .mac_carry_o (mac_carry)
  );

  mulh_ctrl u_mulh_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .req_i        (req_i),
    .ex_ready_i   (ex_ready_i),
    .mac_carry_i  (mac_carry),
    .ctl_o        (mulh_ctl),
    .multicycle_o (multicycle_o),
    .ready_o      (ready_o)
  );

  subword_dot #(.LANE_W(8))      u_dot8  (.req_i(req_i), .result_o(dot8_result));
  subword_dot #(.LANE_W(4))      u_dot4  (.req_i(req_i), .result_o(dot4_result));
  subword_dot #(.LANE_W(2))      u_dot2  (.req_i(req_i), .result_o(dot2_result));
  subword_dot #(.LANE_W(HALF_W)) u_dot16 (.req_i(req_i), .result_o(dot16_result));

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT4:             result_o = dot4_result;
      MUL_DOT2:             result_o = dot2_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // High-word result checks
  ////////////////////////////////////////////////////////////

  logic [2*DATA_W-1:0] prod_ss;
  logic [2*DATA_W-1:0] prod_su;
  logic [2*DATA_W-1:0] prod_uu;
  logic                mulh_done;

  assign prod_ss = $signed({{DATA_W{req_i.op_a[DATA_W-1]}}, req_i.op_a}) *
                   $signed({{DATA_W{req_i.op_b[DATA_W-1]}}, req_i.op_b});
  assign prod_su = {{DATA_W{req_i.op_a[DATA_W-1]}}, req_i.op_a} * {{DATA_W{1'b0}}, req_i.op_b};
  assign prod_uu = {{DATA_W{1'b0}}, req_i.op_a} * {{DATA_W{1'b0}}, req_i.op_b};

  // Only FINISH has the override active while ready is high
  assign mulh_done = mulh_ctl.active && ready_o && (req_i.op == MUL_H);

  a_mulh_signed: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_done && (req_i.short_signed == 2'b11)) |-> (result_o == prod_ss[2*DATA_W-1:DATA_W]));

  a_mulh_su: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_done && (req_i.short_signed == 2'b01)) |-> (result_o == prod_su[2*DATA_W-1:DATA_W]));

  a_mulh_unsigned: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_done && (req_i.short_signed == 2'b00)) |-> (result_o == prod_uu[2*DATA_W-1:DATA_W]));

endmodule

/* subword_dot.sv */
// Lane-parallel dot product
`timescale 1ns/1ps

module subword_dot import mult_pkg::*; #(
  parameter int unsigned LANE_W = 8
) (
  input  mult_req_t         req_i,
  output logic [DATA_W-1:0] result_o
);

  localparam int unsigned LANES  = DATA_W / LANE_W;
  localparam int unsigned PROD_W = 2 * LANE_W + 2;

  logic signed [LANE_W:0]   lane_a    [LANES];
  logic signed [LANE_W:0]   lane_b    [LANES];
  logic signed [PROD_W-1:0] lane_prod [LANES];

  ////////////////////////////////////////////////////////////
  // Lane split and products
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // dot_signed bit 1 extends op_a, bit 0 extends op_b
    assign lane_a[i] = {req_i.dot_signed[1] & req_i.op_a[i*LANE_W+LANE_W-1],
                        req_i.op_a[i*LANE_W +: LANE_W]};
    assign lane_b[i] = {req_i.dot_signed[0] & req_i.op_b[i*LANE_W+LANE_W-1],
                        req_i.op_b[i*LANE_W +: LANE_W]};

    assign lane_prod[i] = lane_a[i] * lane_b[i];
  end

  ////////////////////////////////////////////////////////////
  // Reduction
  ////////////////////////////////////////////////////////////

  // Sign-extended lane products summed onto the accumulator, mod 2^32
  always_comb begin
    result_o = req_i.op_c;
    for (int i = 0; i < LANES; i++) begin
      result_o = result_o + DATA_W'(lane_prod[i]);
    end
  end

endmodule

/* mulh_ctrl.sv */
// High-word multiply sequencer
`timescale 1ns/1ps

module mulh_ctrl import mult_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  input  logic      mac_carry_i,
  output mulh_ctl_t ctl_o,
  output logic      multicycle_o,
  output logic      ready_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  logic        carry_save;
  logic        carry_clear;

  ////////////////////////////////////////////////////////////
  // Next state and step control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d             = state_q;
    ctl_o               = '0;
    ctl_o.active        = 1'b1;
    ctl_o.carry         = carry_q;
    carry_save          = 1'b0;
    carry_clear         = 1'b0;
    ready_o             = 1'b0;
    multicycle_o        = 1'b0;

    case (state_q)
      IDLE: begin
        ctl_o.active = 1'b0;
        ready_o      = 1'b1;
        if (enable_i && (req_i.op == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end

      // AL * BL, both unsigned, no carry possible
      STEP0: begin
        multicycle_o = 1'b1;
        ctl_o.imm    = MULH_SHIFT;
        state_d      = STEP1;
      end

      // AL * BH, signed when b is signed; keep bit 32 of the sum
      STEP1: begin
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {req_i.short_signed[1], 1'b0};
        ctl_o.subword     = 2'b10;
        ctl_o.shift_arith = 1'b1;
        carry_save        = 1'b1;
        state_d           = STEP2;
      end

      // AH * BL, signed when a is signed
      // Bits 33:32 are shifted down here, so the carry is dropped
      STEP2: begin
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {1'b0, req_i.short_signed[0]};
        ctl_o.subword     = 2'b01;
        ctl_o.imm         = MULH_SHIFT;
        ctl_o.shift_arith = 1'b1;
        carry_save        = 1'b1;
        carry_clear       = 1'b1;
        state_d           = FINISH;
      end

      // AH * BH with the requested signedness, held under back-pressure
      FINISH: begin
        ctl_o.signed_sel = req_i.short_signed;
        ctl_o.subword    = 2'b11;
        ready_o          = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and carry registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (carry_save) begin
        carry_q <= ~carry_clear & mac_carry_i;
      end else if (ex_ready_i) begin
        // Next instruction starts clean
        carry_q <= 1'b0;
      end
    end
  end

  a_ready_not_multicycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ready_o && multicycle_o));

  a_step_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((state_q == STEP0) |=> (state_q == STEP1)) and
    ((state_q == STEP1) |=> (state_q == STEP2)));

endmodule

/* short_mult.sv */
// 16x16 short multiplier with shift
`timescale 1ns/1ps

module short_mult import mult_pkg::*; (
  input  mult_req_t         req_i,
  input  mulh_ctl_t         mulh_ctl_i,
  output logic [DATA_W-1:0] result_o,
  output logic              mac_carry_o
);

  logic [IMM_W-1:0]  short_imm;
  logic [1:0]        short_subword;
  logic [1:0]        short_signed;
  logic              short_shift_arith;

  logic [HALF_W-1:0] half_a;
  logic [HALF_W-1:0] half_b;
  logic [HALF_W:0]   ext_a;
  logic [HALF_W:0]   ext_b;
  logic [DATA_W:0]   ext_c;

  logic [DATA_W-1:0] round_tmp;
  logic [DATA_W-1:0] round_val;
  logic [DATA_W+1:0] short_mul;
  logic [DATA_W+1:0] short_mac;
  logic [DATA_W+1:0] short_shifted;
  logic              mac_msb1;
  logic              mac_msb0;

  ////////////////////////////////////////////////////////////
  // Control select
  ////////////////////////////////////////////////////////////

  assign short_imm         = mulh_ctl_i.active ? mulh_ctl_i.imm : req_i.imm;
  assign short_subword     = mulh_ctl_i.active ? mulh_ctl_i.subword
                                               : {2{req_i.short_subword}};
  assign short_signed      = mulh_ctl_i.active ? mulh_ctl_i.signed_sel : req_i.short_signed;
  assign short_shift_arith = mulh_ctl_i.active ? mulh_ctl_i.shift_arith
                                               : req_i.short_signed[0];

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  // subword bit 0 picks the half of op_a, bit 1 the half of op_b
  assign half_a = short_subword[0] ? req_i.op_a[DATA_W-1:HALF_W] : req_i.op_a[HALF_W-1:0];
  assign half_b = short_subword[1] ? req_i.op_b[DATA_W-1:HALF_W] : req_i.op_b[HALF_W-1:0];

  assign ext_a  = {short_signed[0] & half_a[HALF_W-1], half_a};
  assign ext_b  = {short_signed[1] & half_b[HALF_W-1], half_b};

  // The saved carry acts as bit 32 of the running high-word sum
  assign ext_c  = mulh_ctl_i.active ? {mulh_ctl_i.carry, req_i.op_c}
                                    : {req_i.op_c[DATA_W-1], req_i.op_c};

  // Half of 2^imm for the rounding form
  assign round_tmp = 32'h0000_0001 << req_i.imm;
  assign round_val = (req_i.op == MUL_IR) ? {1'b0, round_tmp[DATA_W-1:1]} : '0;

  ////////////////////////////////////////////////////////////
  // Multiply, accumulate, shift
  ////////////////////////////////////////////////////////////

  assign short_mul = $signed(ext_a) * $signed(ext_b);
  assign short_mac = $signed(ext_c) + $signed(short_mul) + $signed({2'b00, round_val});

  // High-word steps keep the two extra sum bits, normal ops extend bit 31
  assign mac_msb1  = mulh_ctl_i.active ? short_mac[DATA_W+1] : short_mac[DATA_W-1];
  assign mac_msb0  = mulh_ctl_i.active ? short_mac[DATA_W]   : short_mac[DATA_W-1];

  assign short_shifted = $signed({short_shift_arith & mac_msb1,
                                  short_shift_arith & mac_msb0,
                                  short_mac[DATA_W-1:0]}) >>> short_imm;

  assign result_o    = short_shifted[DATA_W-1:0];
  assign mac_carry_o = short_mac[DATA_W];

  // Decoder never issues b-signed with a-unsigned to the short unit
  a_short_signed_legal: assert final (
    $isunknown(req_i.op) ||
    !(req_i.op inside {MUL_I, MUL_IR, MUL_H}) ||
    (req_i.short_signed != 2'b10))
    else $error("short_signed 2'b10 on short or high-word op");

endmodule

/* int_mac.sv */
// 32-bit multiply-accumulate datapath
`timescale 1ns/1ps

module int_mac import mult_pkg::*; (
  input  mult_req_t         req_i,
  output logic [DATA_W-1:0] result_o
);

  logic              is_msu;
  logic [DATA_W-1:0] op_a_msu;
  logic [DATA_W-1:0] op_b_msu;
  logic [DATA_W-1:0] product;

  assign is_msu = (req_i.op == MUL_MSU32);

  // Negated product without a separate negator
  // (~a) * b + b equals -(a * b)
  assign op_a_msu = req_i.op_a ^ {DATA_W{is_msu}};
  assign op_b_msu = req_i.op_b & {DATA_W{is_msu}};

  // Low word only, so signedness of the factors does not matter
  assign product  = op_a_msu * req_i.op_b;

  assign result_o = req_i.op_c + op_b_msu + product;

endmodule

/* mult_pkg.sv */
// Subword MAC shared definitions
package mult_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int unsigned DATA_W = 32;
  // Half-word operand width of the short multiplier
  localparam int unsigned HALF_W = 16;
  // Shift immediate width
  localparam int unsigned IMM_W  = 5;
  // Opcode width
  localparam int unsigned OP_W   = 4;

  // Right shift used in the first and third high-word steps
  localparam logic [IMM_W-1:0] MULH_SHIFT = 5'd16;

  ////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////

  typedef enum logic [OP_W-1:0] {
    MUL_MAC32 = 4'h0,
    MUL_MSU32 = 4'h1,
    MUL_I     = 4'h2,
    MUL_IR    = 4'h3,
    MUL_H     = 4'h6,
    MUL_DOT8  = 4'h4,
    MUL_DOT4  = 4'h8,
    MUL_DOT2  = 4'h9,
    MUL_DOT16 = 4'h5
  } mult_op_e;

  // High-word sequencer states
  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // One multiplier request as issued by the EX stage
  typedef struct packed {
    mult_op_e          op;
    logic              short_subword;
    logic [1:0]        short_signed;   // bit 0 for op_a, bit 1 for op_b
    logic [1:0]        dot_signed;     // bit 1 for op_a, bit 0 for op_b
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] op_c;
    logic [IMM_W-1:0]  imm;
  } mult_req_t;

  // Overrides from the high-word sequencer into the short multiplier
  typedef struct packed {
    logic             active;
    logic [IMM_W-1:0] imm;
    logic [1:0]       subword;
    logic [1:0]       signed_sel;
    logic             shift_arith;
    logic             carry;
  } mulh_ctl_t;

endpackage
